// ==== Makefile ====
# Verilator build and run of the lv core testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module lv_core_tb \
		--Mdir $(OBJ_DIR) -o lv_core_sim

run: compile
	./$(OBJ_DIR)/lv_core_sim | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/lv_defs.svh ====
// lv core shared numbers
// register map, widths, reset values and init timing
`ifndef LV_DEFS_SVH
`define LV_DEFS_SVH

// widths
`define LV_DW               8
`define LV_AW               7
`define LV_FRAME_BITS       16
`define LV_ST_W             3

// register addresses
`define LV_ADDR_MODE        7'h00
`define LV_ADDR_CONFIG      7'h01
`define LV_ADDR_STATUS1     7'h02
`define LV_ADDR_STATUS2     7'h03
`define LV_ADDR_STATE       7'h04

// reset values
`define LV_CONFIG_RST       8'h04   // mismatch filter 4 cycles

// cycles spent in init before wait
`define LV_INIT_CYCLES      16

`endif

// ==== project.f ====
+incdir+include
src/lv_pkg.sv
src/lv_reg_if.sv
src/lv_pin_if.sv
src/lv_spi_slv.sv
src/lv_pin_mon.sv
src/lv_reg_slv.sv
src/lv_ctrl_fsm.sv
src/lv_core.sv
tests/lv_clk_gen.sv
tests/lv_core_tb.sv

// ==== src/lv_core.sv ====
// lv die core top
// spi slave, register file, pin monitor and state controller
`timescale 1ns/100ps
`include "lv_defs.svh"

module lv_core (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_spi_sclk,
    input  logic    i_spi_csb,
    input  logic    i_spi_mosi,
    output logic    o_spi_miso,
    input  logic    i_io_fsenb_n,
    input  logic    i_lv_vsup_ov,
    input  logic    i_lv_vsup_uv_n,
    input  logic    i_lv_pwm_dt,
    input  logic    i_lv_gate_vs_pwm,
    output logic    o_dgt_ang_pwm_en,
    output logic    o_dgt_ang_fsc_en,
    output logic    o_intb_n
);

logic                   spi_err;
lv_pkg::mode_t          mode;
lv_pkg::status1_u       status1;
lv_pkg::ctrl_st_e       cur_st;
logic [`LV_DW/2-1:0]    vge_mon_dly;

lv_reg_if u_reg_if ();
lv_pin_if u_pin_if ();

lv_spi_slv u_spi_slv (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_spi_sclk     (i_spi_sclk),
    .i_spi_csb      (i_spi_csb),
    .i_spi_mosi     (i_spi_mosi),
    .o_spi_miso     (o_spi_miso),
    .reg_bus        (u_reg_if.master),
    .o_spi_err      (spi_err)
);

lv_pin_mon u_pin_mon (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_io_fsenb_n       (i_io_fsenb_n),
    .i_lv_vsup_ov       (i_lv_vsup_ov),
    .i_lv_vsup_uv_n     (i_lv_vsup_uv_n),
    .i_lv_pwm_dt        (i_lv_pwm_dt),
    .i_lv_gate_vs_pwm   (i_lv_gate_vs_pwm),
    .i_vge_mon_dly      (vge_mon_dly),
    .pins               (u_pin_if.src)
);

lv_reg_slv u_reg_slv (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .reg_bus        (u_reg_if.slave),
    .pins           (u_pin_if.dst),
    .i_spi_err      (spi_err),
    .i_cur_st       (cur_st),
    .o_mode         (mode),
    .o_status1      (status1),
    .o_vge_mon_dly  (vge_mon_dly)
);

lv_ctrl_fsm u_ctrl_fsm (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_mode         (mode),
    .i_status1      (status1),
    .o_cur_st       (cur_st),
    .o_pwm_en       (o_dgt_ang_pwm_en),
    .o_fsc_en       (o_dgt_ang_fsc_en),
    .o_intb_n       (o_intb_n)
);

endmodule

// ==== src/lv_ctrl_fsm.sv ====
// lv operating state controller
// steps from init through wait to cfg or normal and drops to fault on errors
// drives pwm enable, fail-safe enable and interrupt
`timescale 1ns/100ps
`include "lv_defs.svh"

module lv_ctrl_fsm (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  lv_pkg::mode_t       i_mode,
    input  lv_pkg::status1_u    i_status1,
    output lv_pkg::ctrl_st_e    o_cur_st,
    output logic                o_pwm_en,
    output logic                o_fsc_en,
    output logic                o_intb_n
);

lv_pkg::ctrl_st_e   cur_st;
lv_pkg::ctrl_st_e   nxt_st;
logic [4:0]         init_cnt;
logic               fault;

assign fault = i_status1.flags.pwm_mmerr | i_status1.flags.vsup_uverr
             | i_status1.flags.vsup_overr;   // spi_err only raises intb

always_comb begin
    nxt_st = cur_st;
    case (cur_st)
        lv_pkg::INIT_ST:
            if (init_cnt == 5'(`LV_INIT_CYCLES - 1)) nxt_st = lv_pkg::WAIT_ST;
        lv_pkg::WAIT_ST:
            if (fault)                 nxt_st = lv_pkg::FAULT_ST;
            else if (i_mode.cfg_en)    nxt_st = lv_pkg::CFG_ST;
            else if (i_mode.normal_en) nxt_st = lv_pkg::NML_ST;
        lv_pkg::CFG_ST:
            if (fault)                 nxt_st = lv_pkg::FAULT_ST;
            else if (!i_mode.cfg_en)   nxt_st = lv_pkg::WAIT_ST;
        lv_pkg::NML_ST:
            if (fault)                 nxt_st = lv_pkg::FAULT_ST;
            else if (!i_mode.normal_en) nxt_st = lv_pkg::WAIT_ST;
        lv_pkg::FAULT_ST:
            if (i_mode.reset_en && !fault) nxt_st = lv_pkg::WAIT_ST;
        default: nxt_st = lv_pkg::INIT_ST;
    endcase
end

// ==================================================
// state and output registers
// ==================================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        cur_st   <= lv_pkg::INIT_ST;
        init_cnt <= '0;
        o_pwm_en <= 1'b0;
        o_fsc_en <= 1'b0;
        o_intb_n <= 1'b1;
    end else begin
        cur_st   <= nxt_st;
        if (cur_st == lv_pkg::INIT_ST)
            init_cnt <= init_cnt + 1'b1;
        o_pwm_en <= (nxt_st == lv_pkg::NML_ST);     // aligned with state
        o_fsc_en <= (nxt_st == lv_pkg::FAULT_ST);
        o_intb_n <= ~|i_status1.raw;
    end
end

assign o_cur_st = cur_st;

// pwm stops the cycle after any fault flag
a_pwm_off_on_fault: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    fault |=> !o_pwm_en);

// fault state left only on a reset_en strobe
a_fault_exit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(o_fsc_en) |-> $past(i_mode.reset_en));

endmodule

// ==== src/lv_pin_if.sv ====
// synchronized pin conditions from pin monitor to register file
`timescale 1ns/100ps

interface lv_pin_if;
    logic fsenb_n;
    logic vsup_ov;
    logic vsup_uv;      // active high here
    logic pwm_mmerr;

    modport src (output fsenb_n, vsup_ov, vsup_uv, pwm_mmerr);
    modport dst (input fsenb_n, vsup_ov, vsup_uv, pwm_mmerr);
endinterface

// ==== src/lv_pin_mon.sv ====
// lv pin monitor
// double-flop sync of supply, fail-safe and gate/pwm inputs,
// gate vs pwm mismatch filter
`timescale 1ns/100ps
`include "lv_defs.svh"

module lv_pin_mon (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_io_fsenb_n,
    input  logic                  i_lv_vsup_ov,
    input  logic                  i_lv_vsup_uv_n,
    input  logic                  i_lv_pwm_dt,
    input  logic                  i_lv_gate_vs_pwm,
    input  logic [`LV_DW/2-1:0]   i_vge_mon_dly,
    lv_pin_if.src                 pins
);

// bit order: fsenb_n, vsup_ov, vsup_uv, pwm_dt, gate_vs_pwm
logic [4:0]             sync1;
logic [4:0]             sync2;
logic                   diff;
logic [`LV_DW/2-1:0]    mm_cnt;

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        sync1 <= 5'b10000;
        sync2 <= 5'b10000;
    end else begin
        sync1 <= {i_io_fsenb_n, i_lv_vsup_ov, ~i_lv_vsup_uv_n,
                  i_lv_pwm_dt, i_lv_gate_vs_pwm};
        sync2 <= sync1;
    end
end

assign diff = sync2[1] ^ sync2[0];

// saturating run length of disagreement
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
        mm_cnt <= '0;
    else if (!diff)
        mm_cnt <= '0;
    else if (mm_cnt != '1)
        mm_cnt <= mm_cnt + 1'b1;
end

assign pins.fsenb_n   = sync2[4];
assign pins.vsup_ov   = sync2[3];
assign pins.vsup_uv   = sync2[2];
assign pins.pwm_mmerr = diff && (mm_cnt >= i_vge_mon_dly);

endmodule

// ==== src/lv_pkg.sv ====
// lv core types
// operating states, sticky error register views, mode register fields
`include "lv_defs.svh"

package lv_pkg;

    // operating state codes
    typedef enum logic [`LV_ST_W-1:0] {
        INIT_ST  = 3'd0,
        WAIT_ST  = 3'd1,
        CFG_ST   = 3'd2,
        NML_ST   = 3'd3,
        FAULT_ST = 3'd4
    } ctrl_st_e;

    // sticky errors, raw byte or named flags
    typedef union packed {
        logic [`LV_DW-1:0] raw;
        struct packed {
            logic [3:0] rsvd;       // read 0
            logic       vsup_overr;
            logic       vsup_uverr;
            logic       pwm_mmerr;
            logic       spi_err;
        } flags;
    } status1_u;

    typedef struct packed {
        logic [4:0] rsvd;
        logic       reset_en;       // one-cycle strobe
        logic       cfg_en;
        logic       normal_en;
    } mode_t;

endpackage

// ==== src/lv_reg_if.sv ====
// register access bus between spi slave and register file
// single-cycle strobes, ack and read data one cycle later
`timescale 1ns/100ps
`include "lv_defs.svh"

interface lv_reg_if;
    logic              wr_req;
    logic              rd_req;
    logic [`LV_AW-1:0] addr;
    logic [`LV_DW-1:0] wdata;
    logic              ack;
    logic [`LV_DW-1:0] rdata;   // 0 on writes

    modport master (output wr_req, rd_req, addr, wdata, input ack, rdata);
    modport slave  (input wr_req, rd_req, addr, wdata, output ack, rdata);
endinterface

// ==== src/lv_reg_slv.sv ====
// lv register file
// mode, config, sticky status1 (write 1 to clear), live status2, state
// every strobe acked one cycle later
`timescale 1ns/100ps
`include "lv_defs.svh"

module lv_reg_slv (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    lv_reg_if.slave               reg_bus,
    lv_pin_if.dst                 pins,
    input  logic                  i_spi_err,
    input  lv_pkg::ctrl_st_e      i_cur_st,
    output lv_pkg::mode_t         o_mode,
    output lv_pkg::status1_u      o_status1,
    output logic [`LV_DW/2-1:0]   o_vge_mon_dly
);

lv_pkg::mode_t      mode_q;
logic [`LV_DW-1:0]  config_q;
lv_pkg::status1_u   status1_q;
lv_pkg::status1_u   status1_set;
logic [`LV_DW-1:0]  status1_clr;
logic [`LV_DW-1:0]  rd_mux;
logic               wr_mode;
logic               wr_cfg;
logic               wr_st1;

assign wr_mode = reg_bus.wr_req && (reg_bus.addr == `LV_ADDR_MODE);
assign wr_cfg  = reg_bus.wr_req && (reg_bus.addr == `LV_ADDR_CONFIG)
                 && (i_cur_st == lv_pkg::CFG_ST);   // ignored outside cfg but still acked
assign wr_st1  = reg_bus.wr_req && (reg_bus.addr == `LV_ADDR_STATUS1);

always_comb begin
    status1_set                  = '0;
    status1_set.flags.spi_err    = i_spi_err;
    status1_set.flags.pwm_mmerr  = pins.pwm_mmerr;
    status1_set.flags.vsup_uverr = pins.vsup_uv;
    status1_set.flags.vsup_overr = pins.vsup_ov;
end

assign status1_clr = wr_st1 ? reg_bus.wdata : '0;

// ==================================================
// register storage
// ==================================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        mode_q    <= '0;
        config_q  <= `LV_CONFIG_RST;
        status1_q <= '0;
    end else begin
        if (wr_mode)
            mode_q <= {{(`LV_DW-3){1'b0}}, reg_bus.wdata[2:0]};
        else
            mode_q.reset_en <= 1'b0;    // self clear
        if (wr_cfg)
            config_q <= reg_bus.wdata;
        // set wins over clear while condition persists
        status1_q.raw <= (status1_q.raw & ~status1_clr) | status1_set.raw;
    end
end

always_comb begin
    case (reg_bus.addr)
        `LV_ADDR_MODE:    rd_mux = {{(`LV_DW-2){1'b0}}, mode_q.cfg_en, mode_q.normal_en};
        `LV_ADDR_CONFIG:  rd_mux = config_q;
        `LV_ADDR_STATUS1: rd_mux = status1_q.raw;
        `LV_ADDR_STATUS2: rd_mux = {{(`LV_DW-3){1'b0}}, pins.vsup_uv, pins.vsup_ov,
                                    pins.fsenb_n};
        `LV_ADDR_STATE:   rd_mux = {{(`LV_DW-`LV_ST_W){1'b0}}, i_cur_st};
        default:          rd_mux = '0;
    endcase
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        reg_bus.ack   <= 1'b0;
        reg_bus.rdata <= '0;
    end else begin
        reg_bus.ack   <= reg_bus.wr_req | reg_bus.rd_req;
        reg_bus.rdata <= reg_bus.rd_req ? rd_mux : '0;
    end
end

assign o_mode        = mode_q;
assign o_status1     = status1_q;
assign o_vge_mon_dly = config_q[`LV_DW/2-1:0];

// ack is a one-cycle pulse
a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    reg_bus.ack |=> !reg_bus.ack);

endmodule

// ==== src/lv_spi_slv.sv ====
// lv spi slave
// oversampled mode-0 spi, 16-bit frames: wr flag, 7-bit addr, 8-bit data
// issues register strobes and shifts read data out on miso
`timescale 1ns/100ps
`include "lv_defs.svh"

module lv_spi_slv (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_spi_sclk,
    input  logic    i_spi_csb,
    input  logic    i_spi_mosi,
    output logic    o_spi_miso,
    lv_reg_if.master reg_bus,
    output logic    o_spi_err
);

logic [2:0]                 sclk_sr;
logic [2:0]                 csb_sr;
logic [1:0]                 mosi_sr;
logic                       sclk_rise;
logic                       sclk_fall;
logic                       csb_rise;
logic                       frame_act;
logic                       rise_q;
logic [4:0]                 bit_cnt;
logic [`LV_FRAME_BITS-1:0]  shift_in;
logic [`LV_DW-1:0]          tx_sr;

// ==================================================
// pin sync and edge detect
// ==================================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        sclk_sr <= 3'b000;
        csb_sr  <= 3'b111;  // idle high
        mosi_sr <= 2'b00;
    end else begin
        sclk_sr <= {sclk_sr[1:0], i_spi_sclk};
        csb_sr  <= {csb_sr[1:0], i_spi_csb};
        mosi_sr <= {mosi_sr[0], i_spi_mosi};
    end
end

assign frame_act = ~csb_sr[1];
assign sclk_rise = sclk_sr[1] & ~sclk_sr[2] & frame_act;
assign sclk_fall = ~sclk_sr[1] & sclk_sr[2] & frame_act;
assign csb_rise  = csb_sr[1] & ~csb_sr[2];

// ==================================================
// bit counting and command framing
// ==================================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        bit_cnt <= '0;
        rise_q  <= 1'b0;
    end else begin
        rise_q <= sclk_rise;
        if (!frame_act)
            bit_cnt <= '0;  // still valid in csb-rise cycle
        else if (sclk_rise && bit_cnt != 5'h1f)
            bit_cnt <= bit_cnt + 1'b1;
    end
end

always_ff @(posedge i_clk) begin
    if (sclk_rise)
        shift_in <= {shift_in[`LV_FRAME_BITS-2:0], mosi_sr[1]};
end

// strobes, addr and wdata held until the next access
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        reg_bus.rd_req <= 1'b0;
        reg_bus.wr_req <= 1'b0;
        o_spi_err      <= 1'b0;
    end else begin
        // read: byte 8 done, wr flag clear
        reg_bus.rd_req <= rise_q && frame_act && (bit_cnt == 5'(`LV_FRAME_BITS / 2))
                          && !shift_in[`LV_DW-1];
        reg_bus.wr_req <= csb_rise && (bit_cnt == 5'(`LV_FRAME_BITS))
                          && shift_in[`LV_FRAME_BITS-1];
        o_spi_err      <= csb_rise && (bit_cnt != 5'(`LV_FRAME_BITS));
    end
end

always_ff @(posedge i_clk) begin
    if (rise_q && bit_cnt == 5'(`LV_FRAME_BITS / 2))
        reg_bus.addr <= shift_in[`LV_AW-1:0];
    else if (csb_rise) begin
        reg_bus.addr  <= shift_in[`LV_FRAME_BITS-2 -: `LV_AW];
        reg_bus.wdata <= shift_in[`LV_DW-1:0];
    end
end

// ==================================================
// miso, msb first from the eighth fall
// ==================================================
always_ff @(posedge i_clk) begin
    if (!frame_act)
        tx_sr <= '0;
    else if (reg_bus.ack)
        tx_sr <= reg_bus.rdata;
    else if (sclk_fall && bit_cnt >= 5'(`LV_FRAME_BITS / 2))
        tx_sr <= {tx_sr[`LV_DW-2:0], 1'b0};
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
        o_spi_miso <= 1'b0;
    else if (!frame_act)
        o_spi_miso <= 1'b0;
    else if (sclk_fall && bit_cnt >= 5'(`LV_FRAME_BITS / 2))
        o_spi_miso <= tx_sr[`LV_DW-1];
end

endmodule

// ==== tests/lv_clk_gen.sv ====
// testbench clock source
// free-running clock, 20 ns period
`timescale 1ns/100ps

module lv_clk_gen (
    output logic o_clk
);

localparam int HALF_NS = 10;

initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
end

endmodule

// ==== tests/lv_core_tb.sv ====
// lv core testbench
// table of spi accesses and pin events applied in a loop,
// read data or output pins compared after every row
`timescale 1ns/100ps
`include "lv_defs.svh"

module lv_core_tb;

localparam int HALF    = 10;        // clk cycles per sclk half period
localparam int ROW_CYC = 400;       // rough upper bound per row

localparam logic [2:0] OP_RD    = 3'd0;
localparam logic [2:0] OP_WR    = 3'd1;
localparam logic [2:0] OP_SHORT = 3'd2;
localparam logic [2:0] OP_NOP   = 3'd3;
localparam logic [2:0] OP_PULSE = 3'd4;    // data = pulse length in cycles

// pins: fsenb_n, vsup_ov, vsup_uv_n, pwm_dt, gate_vs_pwm
localparam logic [4:0] PIN_IDLE = 5'b10100;
localparam logic [4:0] PIN_MM   = 5'b10101;
localparam logic [4:0] PIN_OV   = 5'b11100;

// outputs: intb_n, fsc_en, pwm_en
localparam logic [7:0] EXP_WAIT    = 8'h04;
localparam logic [7:0] EXP_NML     = 8'h05;
localparam logic [7:0] EXP_NML_INT = 8'h01;
localparam logic [7:0] EXP_FLT_INT = 8'h02;
localparam logic [7:0] EXP_FLT     = 8'h06;

typedef struct packed {
    logic [2:0]         op;
    logic [`LV_AW-1:0]  addr;
    logic [`LV_DW-1:0]  data;
    logic [4:0]         pins;
    logic [`LV_DW-1:0]  expv;
} row_t;

logic   clk;
logic   rst_n;
logic   spi_sclk;
logic   spi_csb;
logic   spi_mosi;
logic   spi_miso;
logic   io_fsenb_n;
logic   vsup_ov;
logic   vsup_uv_n;
logic   pwm_dt;
logic   gate_vs_pwm;
logic   pwm_en;
logic   fsc_en;
logic   intb_n;

row_t   rows[$];
string  names[$];
integer seed = 32'h8343;
int     err_cnt = 0;
int     cyc_cnt = 0;
int     max_cyc = 0;

lv_clk_gen u_clk_gen (.o_clk(clk));

lv_core UUT (
    .i_clk              (clk),
    .i_rst_n            (rst_n),
    .i_spi_sclk         (spi_sclk),
    .i_spi_csb          (spi_csb),
    .i_spi_mosi         (spi_mosi),
    .o_spi_miso         (spi_miso),
    .i_io_fsenb_n       (io_fsenb_n),
    .i_lv_vsup_ov       (vsup_ov),
    .i_lv_vsup_uv_n     (vsup_uv_n),
    .i_lv_pwm_dt        (pwm_dt),
    .i_lv_gate_vs_pwm   (gate_vs_pwm),
    .o_dgt_ang_pwm_en   (pwm_en),
    .o_dgt_ang_fsc_en   (fsc_en),
    .o_intb_n           (intb_n)
);

// ==================================================
// helpers
// ==================================================
task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #2;     // drive point after the edge
endtask

task automatic drive_pins(input logic [4:0] p);
    {io_fsenb_n, vsup_ov, vsup_uv_n, pwm_dt, gate_vs_pwm} = p;
endtask

// mode 0, msb first; miso captured before rises 9..16
task automatic spi_frame(input logic [15:0] frame, input int nbits,
                         output logic [7:0] rd);
    int b;
    rd = '0;
    spi_csb = 1'b0;
    for (b = 0; b < nbits; b++) begin
        spi_mosi = frame[15-b];
        wait_clk(HALF);
        if (b >= 8)
            rd = {rd[6:0], spi_miso};
        spi_sclk = 1'b1;
        wait_clk(HALF);
        spi_sclk = 1'b0;
    end
    wait_clk(HALF);
    spi_csb = 1'b1;
    wait_clk(HALF);
endtask

task automatic check_val(input string name, input logic [7:0] expv,
                         input logic [7:0] act);
    if (act !== expv) begin
        $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expv, act);
        err_cnt++;
    end
endtask

task automatic add_row(input string name, input logic [2:0] op,
                       input logic [`LV_AW-1:0] addr, input logic [7:0] data,
                       input logic [4:0] pins, input logic [7:0] expv);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.pins = pins;
    r.expv = expv;
    rows.push_back(r);
    names.push_back(name);
endtask

task automatic build_table;
    add_row("state after init", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h01);
    add_row("mode after init", OP_RD, `LV_ADDR_MODE, 8'h00, PIN_IDLE, 8'h00);
    add_row("config after init", OP_RD, `LV_ADDR_CONFIG, 8'h00, PIN_IDLE, 8'h04);
    add_row("outputs after init", OP_NOP, 7'h00, 8'h00, PIN_IDLE, EXP_WAIT);
    add_row("config write in wait", OP_WR, `LV_ADDR_CONFIG,
            8'h80 | 8'($random(seed)), PIN_IDLE, EXP_WAIT);
    add_row("config kept in wait", OP_RD, `LV_ADDR_CONFIG, 8'h00, PIN_IDLE, 8'h04);
    add_row("set cfg_en", OP_WR, `LV_ADDR_MODE, 8'h02, PIN_IDLE, EXP_WAIT);
    add_row("state cfg", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h02);
    add_row("config write in cfg", OP_WR, `LV_ADDR_CONFIG, 8'h05, PIN_IDLE, EXP_WAIT);
    add_row("config readback", OP_RD, `LV_ADDR_CONFIG, 8'h00, PIN_IDLE, 8'h05);
    add_row("clear cfg_en", OP_WR, `LV_ADDR_MODE, 8'h00, PIN_IDLE, EXP_WAIT);
    add_row("state back to wait", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h01);
    add_row("set normal_en", OP_WR, `LV_ADDR_MODE, 8'h01, PIN_IDLE, EXP_NML);
    add_row("state normal", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h03);
    add_row("short frame", OP_SHORT, `LV_ADDR_MODE, 8'h00, PIN_IDLE, EXP_NML_INT);
    add_row("spi_err flag", OP_RD, `LV_ADDR_STATUS1, 8'h00, PIN_IDLE, 8'h01);
    add_row("state after spi_err", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h03);
    add_row("clear spi_err", OP_WR, `LV_ADDR_STATUS1, 8'h01, PIN_IDLE, EXP_NML);
    add_row("short mismatch", OP_PULSE, 7'h00, 8'd3, PIN_MM, EXP_NML);
    add_row("no flag on short mismatch", OP_RD, `LV_ADDR_STATUS1, 8'h00, PIN_IDLE,
            8'h00);
    add_row("long mismatch", OP_PULSE, 7'h00, 8'd10, PIN_MM, EXP_FLT_INT);
    add_row("state fault", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h04);
    add_row("mismatch flag", OP_RD, `LV_ADDR_STATUS1, 8'h00, PIN_IDLE, 8'h02);
    add_row("clear mismatch", OP_WR, `LV_ADDR_STATUS1, 8'h02, PIN_IDLE, EXP_FLT);
    add_row("reset_en", OP_WR, `LV_ADDR_MODE, 8'h04, PIN_IDLE, EXP_WAIT);
    add_row("state after reset_en", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_IDLE, 8'h01);
    add_row("overvoltage high", OP_NOP, 7'h00, 8'h00, PIN_OV, EXP_FLT_INT);
    add_row("overvoltage flag", OP_RD, `LV_ADDR_STATUS1, 8'h00, PIN_OV, 8'h08);
    add_row("status2 live ov", OP_RD, `LV_ADDR_STATUS2, 8'h00, PIN_OV, 8'h03);
    add_row("state fault on ov", OP_RD, `LV_ADDR_STATE, 8'h00, PIN_OV, 8'h04);
    add_row("overvoltage release", OP_NOP, 7'h00, 8'h00, PIN_IDLE, EXP_FLT_INT);
    add_row("status2 after release", OP_RD, `LV_ADDR_STATUS2, 8'h00, PIN_IDLE, 8'h01);
endtask

// ==================================================
// run limit
// ==================================================
always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (max_cyc != 0 && cyc_cnt >= max_cyc) begin
        $display("timeout: the run did not finish within %0d cycles", max_cyc);
        $display("=== FAIL ===");
        $finish;
    end
end

// ==================================================
// main sequence
// ==================================================
initial begin
    int          i;
    row_t        r;
    logic [4:0]  hold_pins;
    logic [7:0]  rd;

    rst_n    = 1'b0;
    spi_sclk = 1'b0;
    spi_csb  = 1'b1;
    spi_mosi = 1'b0;
    drive_pins(PIN_IDLE);
    hold_pins = PIN_IDLE;

    build_table();
    max_cyc = rows.size() * ROW_CYC + 1000;

    wait_clk(10);
    rst_n = 1'b1;
    wait_clk(`LV_INIT_CYCLES + 4);     // init state length

    for (i = 0; i < rows.size(); i++) begin
        r  = rows[i];
        rd = '0;
        if (r.op == OP_PULSE) begin
            drive_pins(r.pins);
            wait_clk(int'(r.data));
            drive_pins(hold_pins);
        end else begin
            hold_pins = r.pins;
            drive_pins(r.pins);
        end
        case (r.op)
            OP_RD:    spi_frame({1'b0, r.addr, 8'h00}, 16, rd);
            OP_WR:    spi_frame({1'b1, r.addr, r.data}, 16, rd);
            OP_SHORT: spi_frame({1'b1, r.addr, r.data}, 12, rd);
            default:  ;
        endcase
        wait_clk(10);
        if (r.op == OP_RD)
            check_val(names[i], r.expv, rd);
        else
            check_val(names[i], r.expv, {5'b00000, intb_n, fsc_en, pwm_en});
    end

    $display("rows run: %0d, errors: %0d", rows.size(), err_cnt);
    if (err_cnt == 0)
        $display("=== PASS ===");
    else
        $display("=== FAIL ===");
    $finish;
end

endmodule
